// ==== hw/sd_card_cmd.sv ====
// SD card command line responder
// Samples a 48-bit command token, waits a fixed gap, then answers with a
// 48-bit response closed by its own CRC7 and an end bit.
// Knows CMD8, CMD55 and ACMD41; other indices get a zero argument
`timescale 1ns/100ps
`default_nettype none

module sd_card_cmd #(
    parameter int POWERUP_DELAY = 200
) (
    input  wire logic i_sclk,
    input  wire logic i_nrst,
    input  wire logic i_cmd,
    output logic      o_cmd,
    output logic      o_cmd_oe
);

    import sd_cmd_pkg::*;

    localparam int        PU_W                = $clog2(POWERUP_DELAY + 2);
    localparam sd_index_t IDX_SEND_IF_COND    = 6'h08;
    localparam sd_index_t IDX_SD_SEND_OP_COND = 6'h29;

    card_state_e               state_q, state_d;
    logic [5:0]                bitcnt_q, bitcnt_d;
    logic                      drive_q, drive_d;
    logic [PU_W-1:0]           pu_cnt_q;
    logic                      powerup_done;
    logic                      receiving;
    logic [CMD_FRAME_BITS-1:0] rx_shift_q, rx_shift_d;
    logic [39:0]               tx_shift_q, tx_shift_d;
    logic                      crc_clear;
    logic                      crc_next;
    logic                      crc_dat;
    sd_crc7_t                  crc7;
    logic [7:0]                crc_tail;
    sd_index_t                 req_index;
    sd_arg_t                   req_arg;
    sd_index_t                 resp_index;
    sd_arg_t                   resp_arg;

    sd_crc7 u_crc7 (
        .i_sclk  (i_sclk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc7)
    );

    // Power-up counter saturates at POWERUP_DELAY
    always_ff @(posedge i_sclk or negedge i_nrst) begin
        if (!i_nrst) begin
            pu_cnt_q <= '0;
        end else if (!powerup_done) begin
            pu_cnt_q <= pu_cnt_q + 1'b1;
        end
    end

    assign powerup_done = (pu_cnt_q == PU_W'(POWERUP_DELAY));

    // Captured request fields, valid once the stop bit is shifted in
    assign req_index = rx_shift_q[45:40];
    assign req_arg   = rx_shift_q[39:8];

    always_comb begin
        resp_index = req_index;
        resp_arg   = '0;
        case (req_index)
            IDX_SEND_IF_COND: begin
                // Voltage accepted and check pattern echoed
                resp_arg[13]   = req_arg[13] & CFG_PCIE_1_2V;
                resp_arg[12]   = req_arg[12] & CFG_PCIE_AVAIL;
                resp_arg[11:8] = req_arg[11:8] & CFG_VHS;
                resp_arg[7:0]  = req_arg[7:0];
            end
            IDX_SD_SEND_OP_COND: begin
                // OCR with busy bit high once power-up is done
                resp_index     = IDX_RESP_R3;
                resp_arg[31]   = powerup_done;
                resp_arg[23:0] = req_arg[23:0] & CFG_VDD_WINDOW;
            end
            default: begin
                // CMD55 and everything else answer with a zero argument
                resp_arg = '0;
            end
        endcase
    end

    assign receiving = state_q inside {CS_IDLE, CS_REQ_START, CS_REQ_BODY,
                                       CS_REQ_CRC, CS_REQ_STOP};

    always_comb begin
        state_d    = state_q;
        bitcnt_d   = bitcnt_q;
        drive_d    = drive_q;
        rx_shift_d = rx_shift_q;
        tx_shift_d = tx_shift_q;
        crc_clear  = 1'b0;
        crc_next   = 1'b0;
        crc_dat    = i_cmd;

        // Stop bit included, so the whole token ends up in rx_shift
        if (receiving) begin
            rx_shift_d = {rx_shift_q[CMD_FRAME_BITS-2:0], i_cmd};
        end

        case (state_q)
            CS_IDLE: begin
                if (!i_cmd) begin
                    crc_next = 1'b1;
                    state_d  = CS_REQ_START;
                end else begin
                    crc_clear = 1'b1;
                end
            end
            CS_REQ_START: begin
                // Transmission bit must be 1 for a host command
                if (i_cmd) begin
                    crc_next = 1'b1;
                    bitcnt_d = 6'd37;
                    state_d  = CS_REQ_BODY;
                end else begin
                    crc_clear = 1'b1;
                    state_d   = CS_IDLE;
                end
            end
            CS_REQ_BODY: begin
                crc_next = 1'b1;
                if (bitcnt_q == '0) begin
                    bitcnt_d = 6'd6;
                    state_d  = CS_REQ_CRC;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            CS_REQ_CRC: begin
                if (bitcnt_q == '0) begin
                    state_d = CS_REQ_STOP;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            CS_REQ_STOP: begin
                crc_clear = 1'b1;
                bitcnt_d  = 6'(RESP_GAP_CYCLES);
                state_d   = CS_WAIT_RESP;
            end
            CS_WAIT_RESP: begin
                if (bitcnt_q == '0) begin
                    // Start bit 0, transmission bit 0 for a card response
                    tx_shift_d = {2'b00, resp_index, resp_arg};
                    bitcnt_d   = 6'd39;
                    drive_d    = 1'b1;
                    state_d    = CS_RESP_BODY;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            CS_RESP_BODY: begin
                crc_dat    = tx_shift_q[39];
                crc_next   = 1'b1;
                tx_shift_d = {tx_shift_q[38:0], 1'b1};
                if (bitcnt_q == '0) begin
                    bitcnt_d = 6'd7;
                    state_d  = CS_RESP_CRC;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            CS_RESP_CRC: begin
                if (bitcnt_q == '0) begin
                    drive_d = 1'b0;
                    state_d = CS_IDLE;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            default: begin
                state_d = CS_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_sclk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q  <= CS_IDLE;
            bitcnt_q <= '0;
            drive_q  <= 1'b0;
        end else begin
            state_q  <= state_d;
            bitcnt_q <= bitcnt_d;
            drive_q  <= drive_d;
        end
    end

    always_ff @(posedge i_sclk) begin
        rx_shift_q <= rx_shift_d;
        tx_shift_q <= tx_shift_d;
    end

    // CRC7 is held during RESP_CRC, so the tail is picked by bit count
    assign crc_tail = {crc7, 1'b1};
    assign o_cmd    = (state_q == CS_RESP_CRC) ? crc_tail[bitcnt_q[2:0]] : tx_shift_q[39];
    assign o_cmd_oe = drive_q;

    no_drive_in_rx_a: assert property (@(posedge i_sclk) disable iff (!i_nrst)
        receiving |-> !o_cmd_oe);

    // The host token carries a CRC7 that matches the card's own sum
    req_crc_a: assert property (@(posedge i_sclk) disable iff (!i_nrst)
        (state_q == CS_REQ_STOP) |-> (rx_shift_q[6:0] == crc7));

endmodule

`default_nettype wire

// ==== hw/sd_cmd_pkg.sv ====
// SD command line shared definitions
// Widths, request and response structs, FSM encodings and the
// configuration the card model reports back to the host
`default_nettype none

package sd_cmd_pkg;

    // Field widths of the command token
    typedef logic [5:0]  sd_index_t;
    typedef logic [31:0] sd_arg_t;
    typedef logic [6:0]  sd_crc7_t;

    // Request from the user side to the host controller
    typedef struct packed {
        sd_index_t index;
        sd_arg_t   arg;
    } sd_cmd_req_t;

    // Decoded response handed back to the user side
    typedef struct packed {
        sd_index_t index;
        sd_arg_t   arg;
        logic      crc_ok;
        logic      timeout;
    } sd_cmd_resp_t;

    // Card side FSM
    typedef enum logic [2:0] {
        CS_IDLE,
        CS_REQ_START,
        CS_REQ_BODY,
        CS_REQ_CRC,
        CS_REQ_STOP,
        CS_WAIT_RESP,
        CS_RESP_BODY,
        CS_RESP_CRC
    } card_state_e;

    // Host side FSM
    typedef enum logic [2:0] {
        HS_IDLE,
        HS_SEND,
        HS_WAIT_START,
        HS_RECV,
        HS_DONE
    } host_state_e;

    // Card configuration reported in CMD8 and ACMD41 responses
    localparam logic        CFG_PCIE_1_2V  = 1'b0;
    localparam logic        CFG_PCIE_AVAIL = 1'b1;
    localparam logic [3:0]  CFG_VHS        = 4'b0001;
    localparam logic [23:0] CFG_VDD_WINDOW = 24'hFF8000;

    localparam int        CMD_FRAME_BITS  = 48;
    // Clocks from the request stop bit to the response start bit
    localparam int        RESP_GAP_CYCLES = 10;
    // R3 responses carry all ones in the index field
    localparam sd_index_t IDX_RESP_R3     = 6'h3F;

endpackage

`default_nettype wire

// ==== hw/sd_cmd_top.sv ====
// SD command line subsystem
// Host controller and card model joined by an open-drain style
// command line with a pull-up
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_top #(
    parameter int POWERUP_DELAY = 200,
    parameter int RESP_TIMEOUT  = 64
) (
    input  wire logic                    i_sclk,
    input  wire logic                    i_nrst,
    input  wire sd_cmd_pkg::sd_cmd_req_t i_req,
    input  wire logic                    i_req_valid,
    output logic                         o_req_ready,
    output sd_cmd_pkg::sd_cmd_resp_t     o_resp,
    output logic                         o_resp_valid,
    input  wire logic                    i_resp_ready,
    output logic                         o_cmd_line
);

    logic host_cmd;
    logic host_oe;
    logic card_cmd;
    logic card_oe;
    logic cmd_line;

    sd_host_cmd #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_host (
        .i_sclk       (i_sclk),
        .i_nrst       (i_nrst),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_resp       (o_resp),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready),
        .i_cmd        (cmd_line),
        .o_cmd        (host_cmd),
        .o_cmd_oe     (host_oe)
    );

    sd_card_cmd #(
        .POWERUP_DELAY (POWERUP_DELAY)
    ) u_card (
        .i_sclk   (i_sclk),
        .i_nrst   (i_nrst),
        .i_cmd    (cmd_line),
        .o_cmd    (card_cmd),
        .o_cmd_oe (card_oe)
    );

    // Any enabled side driving 0 pulls the line low, else the pull-up wins
    assign cmd_line   = ~((host_oe & ~host_cmd) | (card_oe & ~card_cmd));
    assign o_cmd_line = cmd_line;

endmodule

`default_nettype wire

// ==== hw/sd_crc7.sv ====
// Bit-serial CRC7 generator, polynomial x^7 + x^3 + 1
// Clear resets the remainder, next shifts in one data bit
`timescale 1ns/100ps
`default_nettype none

module sd_crc7 (
    input  wire logic            i_sclk,
    input  wire logic            i_nrst,
    input  wire logic            i_clear,
    input  wire logic            i_next,
    input  wire logic            i_dat,
    output sd_cmd_pkg::sd_crc7_t o_crc7
);

    import sd_cmd_pkg::*;

    sd_crc7_t crc_q;
    logic     fb;

    // Feedback taps land on bits 0 and 3
    assign fb = crc_q[6] ^ i_dat;

    always_ff @(posedge i_sclk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
        end
    end

    assign o_crc7 = crc_q;

    clear_next_excl_a: assert property (@(posedge i_sclk) disable iff (!i_nrst)
        !(i_clear && i_next));

endmodule

`default_nettype wire

// ==== hw/sd_host_cmd.sv ====
// SD host command controller
// Frames a request as a 48-bit token with CRC7, shifts it onto the
// command line, then collects and checks the card response.
// Gives up with a timeout flag if no start bit shows up in time
`timescale 1ns/100ps
`default_nettype none

module sd_host_cmd #(
    parameter int RESP_TIMEOUT = 64
) (
    input  wire logic                    i_sclk,
    input  wire logic                    i_nrst,
    input  wire sd_cmd_pkg::sd_cmd_req_t i_req,
    input  wire logic                    i_req_valid,
    output logic                         o_req_ready,
    output sd_cmd_pkg::sd_cmd_resp_t     o_resp,
    output logic                         o_resp_valid,
    input  wire logic                    i_resp_ready,
    input  wire logic                    i_cmd,
    output logic                         o_cmd,
    output logic                         o_cmd_oe
);

    import sd_cmd_pkg::*;

    localparam int TMO_W = $clog2(RESP_TIMEOUT + 1);

    host_state_e      state_q, state_d;
    logic [5:0]       bitcnt_q, bitcnt_d;
    logic [TMO_W-1:0] tmo_cnt_q, tmo_cnt_d;
    logic [39:0]      tx_shift_q, tx_shift_d;
    logic [46:0]      rx_shift_q, rx_shift_d;
    logic [47:0]      rx_frame;
    sd_cmd_resp_t     resp_q, resp_d;
    logic             crc_clear;
    logic             crc_next;
    logic             crc_dat;
    sd_crc7_t         crc7;
    logic [7:0]       crc_tail;

    sd_crc7 u_crc7 (
        .i_sclk  (i_sclk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc7)
    );

    // Full response token at the moment the end bit is on the line
    assign rx_frame = {rx_shift_q, i_cmd};

    always_comb begin
        state_d    = state_q;
        bitcnt_d   = bitcnt_q;
        tmo_cnt_d  = tmo_cnt_q;
        tx_shift_d = tx_shift_q;
        rx_shift_d = rx_shift_q;
        resp_d     = resp_q;
        crc_clear  = 1'b0;
        crc_next   = 1'b0;
        crc_dat    = i_cmd;

        case (state_q)
            HS_IDLE: begin
                crc_clear = 1'b1;
                if (i_req_valid) begin
                    tx_shift_d = {2'b01, i_req.index, i_req.arg};
                    bitcnt_d   = 6'(CMD_FRAME_BITS - 1);
                    state_d    = HS_SEND;
                end
            end
            HS_SEND: begin
                // First 40 bits feed the CRC, bits 7..1 carry it out
                crc_dat = tx_shift_q[39];
                if (bitcnt_q >= 6'd8) begin
                    crc_next   = 1'b1;
                    tx_shift_d = {tx_shift_q[38:0], 1'b1};
                end
                if (bitcnt_q == '0) begin
                    crc_clear = 1'b1;
                    tmo_cnt_d = '0;
                    state_d   = HS_WAIT_START;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            HS_WAIT_START: begin
                if (!i_cmd) begin
                    crc_next   = 1'b1;
                    rx_shift_d = {rx_shift_q[45:0], i_cmd};
                    bitcnt_d   = 6'd46;
                    state_d    = HS_RECV;
                end else if (tmo_cnt_q == TMO_W'(RESP_TIMEOUT - 1)) begin
                    resp_d  = '{index: '0, arg: '0, crc_ok: 1'b0, timeout: 1'b1};
                    state_d = HS_DONE;
                end else begin
                    tmo_cnt_d = tmo_cnt_q + 1'b1;
                end
            end
            HS_RECV: begin
                rx_shift_d = {rx_shift_q[45:0], i_cmd};
                if (bitcnt_q >= 6'd8) begin
                    crc_next = 1'b1;
                end
                if (bitcnt_q == '0) begin
                    resp_d.index   = rx_frame[45:40];
                    resp_d.arg     = rx_frame[39:8];
                    resp_d.crc_ok  = (rx_frame[7:1] == crc7);
                    resp_d.timeout = 1'b0;
                    state_d        = HS_DONE;
                end else begin
                    bitcnt_d = bitcnt_q - 1'b1;
                end
            end
            HS_DONE: begin
                if (i_resp_ready) begin
                    state_d = HS_IDLE;
                end
            end
            default: begin
                state_d = HS_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_sclk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q   <= HS_IDLE;
            bitcnt_q  <= '0;
            tmo_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            bitcnt_q  <= bitcnt_d;
            tmo_cnt_q <= tmo_cnt_d;
        end
    end

    always_ff @(posedge i_sclk) begin
        tx_shift_q <= tx_shift_d;
        rx_shift_q <= rx_shift_d;
        resp_q     <= resp_d;
    end

    // CRC7 settles before bit 7 goes out and is held until the stop bit
    assign crc_tail     = {crc7, 1'b1};
    assign o_cmd        = (bitcnt_q >= 6'd8) ? tx_shift_q[39] : crc_tail[bitcnt_q[2:0]];
    assign o_cmd_oe     = (state_q == HS_SEND);
    assign o_req_ready  = (state_q == HS_IDLE);
    assign o_resp_valid = (state_q == HS_DONE);
    assign o_resp       = resp_q;

    resp_hold_a: assert property (@(posedge i_sclk) disable iff (!i_nrst)
        (o_resp_valid && !i_resp_ready) |=> (o_resp_valid && $stable(o_resp)));

endmodule

`default_nettype wire

// ==== project.f ====
hw/sd_cmd_pkg.sv
hw/sd_crc7.sv
hw/sd_card_cmd.sv
hw/sd_host_cmd.sv
hw/sd_cmd_top.sv
sim/tb_sd_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module tb_sd_cmd -o tb_sd_cmd
./obj_dir/tb_sd_cmd 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== sim/tb_sd_cmd.sv ====
// Testbench for the SD command line subsystem
// Sends CMD8, CMD55, ACMD41 and other commands through the host,
// checks the frame on the line and every accepted response
`timescale 1ns/100ps
`default_nettype none

module tb_sd_cmd;

    import sd_cmd_pkg::*;

    localparam int POWERUP_DELAY = 150;
    localparam int RESP_TIMEOUT  = 64;
    localparam int WAIT_LIMIT    = 400;

    logic         sclk;
    logic         nrst;
    sd_cmd_req_t  req;
    logic         req_valid;
    logic         req_ready;
    sd_cmd_resp_t resp;
    logic         resp_valid;
    logic         resp_ready;
    logic         cmd_line;

    sd_cmd_resp_t exp_resp;
    string        test_name;
    int           cyc;
    logic         timed_out;
    int           err_resp;
    int           err_hold;
    int           err_line;
    int           err_frame;

    sd_cmd_top #(
        .POWERUP_DELAY (POWERUP_DELAY),
        .RESP_TIMEOUT  (RESP_TIMEOUT)
    ) u_dut (
        .i_sclk       (sclk),
        .i_nrst       (nrst),
        .i_req        (req),
        .i_req_valid  (req_valid),
        .o_req_ready  (req_ready),
        .o_resp       (resp),
        .o_resp_valid (resp_valid),
        .i_resp_ready (resp_ready),
        .o_cmd_line   (cmd_line)
    );

    always #2 sclk = ~sclk;

    // Same count as the card power-up counter until it saturates
    always @(posedge sclk or negedge nrst) begin
        if (!nrst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    resp_check_a: assert property (@(posedge sclk) disable iff (!nrst)
        (resp_valid && resp_ready) |-> (resp == exp_resp))
    else begin
        err_resp++;
        $display("Error %s: expected %h, actual %h", test_name, exp_resp, resp);
    end

    resp_hold_a: assert property (@(posedge sclk) disable iff (!nrst)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
    else begin
        err_hold++;
        $display("Error %s back-pressure: expected %h, actual %h", test_name, exp_resp, resp);
    end

    ready_low_a: assert property (@(posedge sclk) disable iff (!nrst)
        resp_valid |-> !req_ready)
    else begin
        err_hold++;
        $display("Request ready went high while a response was pending in %s", test_name);
    end

    line_idle_a: assert property (@(posedge sclk) disable iff (!nrst)
        (req_ready || resp_valid) |-> cmd_line)
    else begin
        err_line++;
        $display("Command line was low while the host was idle in %s", test_name);
    end

    // One clock, then the small drive delay
    task automatic step();
        @(posedge sclk);
        #1;
    endtask

    function automatic sd_crc7_t frame_crc7(input logic [39:0] bits);
        sd_crc7_t crc;
        logic     fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = crc[6] ^ bits[i];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // Response the card should give for one command
    function automatic sd_cmd_resp_t expect_resp(input sd_index_t idx, input sd_arg_t arg,
                                                 input logic busy);
        sd_cmd_resp_t r;
        r.index   = idx;
        r.arg     = '0;
        r.crc_ok  = 1'b1;
        r.timeout = 1'b0;
        if (idx == 6'd8) begin
            r.arg[13]   = arg[13] & CFG_PCIE_1_2V;
            r.arg[12]   = arg[12] & CFG_PCIE_AVAIL;
            r.arg[11:8] = arg[11:8] & CFG_VHS;
            r.arg[7:0]  = arg[7:0];
        end else if (idx == 6'd41) begin
            r.index      = IDX_RESP_R3;
            r.arg[31]    = busy;
            r.arg[23:0]  = arg[23:0] & CFG_VDD_WINDOW;
        end
        return r;
    endfunction

    task automatic run_cmd(input sd_index_t idx, input sd_arg_t arg, input string name);
        logic [39:0] head;
        logic [47:0] exp_frame;
        logic [47:0] frame;
        int          guard;
        int          hold;
        if (timed_out) return;
        test_name = name;
        head      = {2'b01, idx, arg};
        exp_frame = {head, frame_crc7(head), 1'b1};
        // Busy is only predicted well clear of the power-up edge
        exp_resp  = expect_resp(idx, arg, cyc >= POWERUP_DELAY);
        req       = '{index: idx, arg: arg};
        req_valid = 1'b1;
        guard     = 0;
        while (!req_ready && guard < WAIT_LIMIT) begin
            step();
            guard++;
        end
        if (!req_ready) begin
            $display("Timeout: request %s was not accepted", name);
            timed_out = 1'b1;
            return;
        end
        step();
        req_valid = 1'b0;
        // Host drives frame bit 47 first, one bit per clock
        for (int i = 47; i >= 0; i--) begin
            frame[i] = cmd_line;
            step();
        end
        assert (frame == exp_frame) else begin
            err_frame++;
            $display("Error %s frame: expected %h, actual %h", name, exp_frame, frame);
        end
        guard = 0;
        while (!resp_valid && guard < WAIT_LIMIT) begin
            step();
            guard++;
        end
        if (!resp_valid) begin
            $display("Timeout: no response for %s", name);
            timed_out = 1'b1;
            return;
        end
        hold = $urandom_range(5, 0);
        repeat (hold) step();
        resp_ready = 1'b1;
        step();
        resp_ready = 1'b0;
    endtask

    initial begin
        int        guard;
        sd_index_t idx;
        sclk       = 1'b0;
        nrst       = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        exp_resp   = '0;
        test_name  = "reset";
        timed_out  = 1'b0;
        err_resp   = 0;
        err_hold   = 0;
        err_line   = 0;
        err_frame  = 0;
        void'($urandom(32'hd79e_583b));

        repeat (3) @(posedge sclk);
        #1;
        assert (cmd_line === 1'b1) else begin
            err_line++;
            $display("Error reset line: expected 1, actual %b", cmd_line);
        end
        nrst = 1'b1;
        step();
        assert (cmd_line === 1'b1) else begin
            err_line++;
            $display("Error idle line: expected 1, actual %b", cmd_line);
        end

        // Card still powering up, busy bit low
        run_cmd(6'd41, $urandom, "acmd41_early");
        repeat (4) run_cmd(6'd8, $urandom, "cmd8");
        repeat (2) run_cmd(6'd55, $urandom, "cmd55");
        repeat (10) begin
            idx = 6'($urandom_range(63, 0));
            if (idx == 6'd8 || idx == 6'd41) begin
                idx = idx + 6'd1;
            end
            run_cmd(idx, $urandom, "other");
        end

        guard = 0;
        while (cyc < POWERUP_DELAY && guard < 2 * WAIT_LIMIT) begin
            step();
            guard++;
        end
        if (cyc < POWERUP_DELAY) begin
            $display("Timeout: power-up delay did not elapse");
            timed_out = 1'b1;
        end
        repeat (2) run_cmd(6'd41, $urandom, "acmd41_late");
        repeat (2) step();

        $display("Errors: response %0d, back-pressure %0d, line %0d, frame %0d",
                 err_resp, err_hold, err_line, err_frame);
        if (timed_out || (err_resp + err_hold + err_line + err_frame) != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire
